/* logic/axi_read_pkg.sv */
`default_nettype none

package axi_read_pkg;

    localparam int AXI_ADDR_W  = 32;
    localparam int AXI_DATA_W  = 32;
    localparam int AXI_LEN_W   = 8;     // full arlen field, beats minus one
    localparam int AXI_SIZE_W  = 3;
    localparam int AXI_BURST_W = 2;

    localparam logic [AXI_BURST_W-1:0] AXI_BURST_FIXED = 2'b00;
    localparam logic [AXI_BURST_W-1:0] AXI_BURST_INCR  = 2'b01;
    localparam logic [AXI_BURST_W-1:0] AXI_BURST_WRAP  = 2'b10;

    // arsize is log2 of the bytes moved per beat
    function automatic logic [AXI_SIZE_W-1:0] axi_size_for(input int unsigned data_w);
        return AXI_SIZE_W'($clog2(data_w / 8));
    endfunction

endpackage

`default_nettype wire

/* logic/refill_pkg.sv */
`default_nettype none

package refill_pkg;
    import axi_read_pkg::*;

    localparam int BEAT_BYTES = AXI_DATA_W / 8;    // one R beat
    localparam int REQ_LEN_W  = 4;                 // beats minus one, up to 16 beats

    // one queued refill, pc already line aligned when it is pushed
    typedef struct packed {
        logic [AXI_ADDR_W-1:0] addr;       // start byte address
        logic [AXI_ADDR_W-1:0] pc_line;    // low offset bits are zero
        logic [REQ_LEN_W-1:0]  len;
    } refill_entry_t;

endpackage

`default_nettype wire

/* logic/refill_head_if.sv */
`default_nettype none

interface refill_head_if
    import axi_read_pkg::*;
    import refill_pkg::*;
();
    logic                  head_valid;  // queue holds an entry
    logic [AXI_ADDR_W-1:0] head_addr;
    logic [AXI_ADDR_W-1:0] head_pc;     // line aligned
    logic [REQ_LEN_W-1:0]  head_len;
    logic                  pop;         // single cycle, drops the head

    modport queue_side (
        output head_valid, head_addr, head_pc, head_len,
        input  pop
    );

    modport reader_side (
        input  head_valid, head_addr, head_pc, head_len,
        output pop
    );

endinterface

`default_nettype wire

/* logic/refill_queue.sv */
`default_nettype none

module refill_queue
    import axi_read_pkg::*;
    import refill_pkg::*;
#(
    parameter int LINE_BYTE_OFFSET = 6,
    parameter int QUEUE_DEPTH      = 4
) (
    input  wire logic          i_clk,
    input  wire logic          i_rst,
    input  wire logic          i_push,
    input  wire refill_entry_t i_entry,
    output logic               o_full,
    refill_head_if.queue_side  head
);

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    // storage split per field, pc keeps only the line bits
    logic [AXI_ADDR_W-1:0]                addr_mem [QUEUE_DEPTH];
    logic [AXI_ADDR_W-1:LINE_BYTE_OFFSET] pc_mem   [QUEUE_DEPTH];
    logic [REQ_LEN_W-1:0]                 len_mem  [QUEUE_DEPTH];

    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             empty;
    logic             wr_en;
    logic             rd_en;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;   // wraps for any depth
    endfunction

    assign empty  = (count_q == '0);
    assign o_full = (count_q == CNT_W'(QUEUE_DEPTH));
    assign wr_en  = i_push & ~o_full;
    assign rd_en  = head.pop & ~empty;

    always_ff @(posedge i_clk) begin
        if (wr_en) begin
            addr_mem[wr_ptr_q] <= i_entry.addr;
            pc_mem[wr_ptr_q]   <= i_entry.pc_line[AXI_ADDR_W-1:LINE_BYTE_OFFSET];
            len_mem[wr_ptr_q]  <= i_entry.len;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr_q <= ptr_inc(wr_ptr_q);
            end
            if (rd_en) begin
                rd_ptr_q <= ptr_inc(rd_ptr_q);
            end
            case ({wr_en, rd_en})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;        // both or neither
            endcase
        end
    end

    // fall-through head, no output register
    assign head.head_valid = ~empty;
    assign head.head_addr  = addr_mem[rd_ptr_q];
    assign head.head_pc    = {pc_mem[rd_ptr_q], {LINE_BYTE_OFFSET{1'b0}}};
    assign head.head_len   = len_mem[rd_ptr_q];

endmodule

`default_nettype wire

/* logic/burst_reader.sv */
`default_nettype none

module burst_reader
    import axi_read_pkg::*;
    import refill_pkg::*;
#(
    parameter int LINE_BYTE_OFFSET = 6
) (
    input  wire logic                  i_clk,
    input  wire logic                  i_rst,
    refill_head_if.reader_side         head,

    output logic                       o_arvalid,
    output logic [AXI_ADDR_W-1:0]      o_araddr,
    output logic [AXI_LEN_W-1:0]       o_arlen,
    input  wire logic                  i_arready,

    input  wire logic                  i_rvalid,
    input  wire logic [AXI_DATA_W-1:0] i_rdata,
    input  wire logic                  i_rlast,

    output logic                       o_beat_valid,
    output logic [AXI_DATA_W-1:0]      o_beat_data,
    output logic [AXI_ADDR_W-1:0]      o_beat_addr,
    output logic [AXI_ADDR_W-1:0]      o_beat_pc,
    output logic                       o_beat_last,
    output logic                       o_idle
);

    localparam int OFF_W = REQ_LEN_W + $clog2(BEAT_BYTES);  // byte offset within one burst

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ADDR,
        ST_DATA
    } state_t;

    state_t                               state_q;
    logic [AXI_ADDR_W-1:0]                beat_addr_q;
    logic [AXI_ADDR_W-1:LINE_BYTE_OFFSET] pc_line_q;   // fixed for the burst
    logic [OFF_W-1:0]                     pc_off_q;
    logic                                 ar_fire;
    logic                                 beat_fire;

    assign ar_fire   = (state_q == ST_ADDR) & i_arready;
    assign beat_fire = (state_q == ST_DATA) & i_rvalid;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state_q <= ST_IDLE;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (head.head_valid) begin
                        state_q <= ST_ADDR;
                    end
                end
                ST_ADDR: begin
                    if (i_arready) begin
                        state_q <= ST_DATA;
                    end
                end
                ST_DATA: begin
                    if (beat_fire && i_rlast) begin
                        state_q <= ST_IDLE;     // one idle cycle before the next AR
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // beat counters, loaded at the AR handshake
    always_ff @(posedge i_clk) begin
        if (ar_fire) begin
            beat_addr_q <= head.head_addr;
            pc_line_q   <= head.head_pc[AXI_ADDR_W-1:LINE_BYTE_OFFSET];
            pc_off_q    <= '0;
        end else if (beat_fire) begin
            beat_addr_q <= beat_addr_q + AXI_ADDR_W'(BEAT_BYTES);
            pc_off_q    <= pc_off_q + OFF_W'(BEAT_BYTES);
        end
    end

    // head stays put until pop, so AR fields are stable
    assign o_arvalid = (state_q == ST_ADDR);
    assign o_araddr  = head.head_addr;
    assign o_arlen   = AXI_LEN_W'(head.head_len);

    assign head.pop  = beat_fire & i_rlast;

    assign o_beat_valid = beat_fire;        // zero latency pass-through
    assign o_beat_data  = i_rdata;
    assign o_beat_last  = i_rlast;
    assign o_beat_addr  = beat_addr_q;
    assign o_beat_pc    = {pc_line_q, {LINE_BYTE_OFFSET{1'b0}}} + AXI_ADDR_W'(pc_off_q);

    assign o_idle = (state_q == ST_IDLE) & ~head.head_valid;

endmodule

`default_nettype wire

/* logic/mem_refill.sv */
`default_nettype none

module mem_refill
    import axi_read_pkg::*;
    import refill_pkg::*;
#(
    parameter int LINE_BYTE_OFFSET = 6,
    parameter int QUEUE_DEPTH      = 4
) (
    input  wire logic                  i_clk,
    input  wire logic                  i_rst,

    input  wire logic                  i_req_valid,
    input  wire logic [AXI_ADDR_W-1:0] i_req_addr,
    input  wire logic [AXI_ADDR_W-1:0] i_req_pc,
    input  wire logic [REQ_LEN_W-1:0]  i_req_len,
    output logic                       o_req_ready,

    output logic                       o_arvalid,
    output logic [AXI_ADDR_W-1:0]      o_araddr,
    output logic [AXI_LEN_W-1:0]       o_arlen,
    output logic [AXI_SIZE_W-1:0]      o_arsize,
    output logic [AXI_BURST_W-1:0]     o_arburst,
    output logic                       o_rready,
    input  wire logic                  i_arready,
    input  wire logic                  i_rvalid,
    input  wire logic [AXI_DATA_W-1:0] i_rdata,
    input  wire logic                  i_rlast,

    output logic                       o_beat_valid,
    output logic [AXI_DATA_W-1:0]      o_beat_data,
    output logic [AXI_ADDR_W-1:0]      o_beat_addr,
    output logic [AXI_ADDR_W-1:0]      o_beat_pc,
    output logic                       o_beat_last,
    output logic                       o_idle
);

    refill_entry_t req_entry;
    logic          req_push;
    logic          queue_full;

    refill_head_if head_if ();

    assign o_req_ready = ~queue_full;
    assign req_push    = i_req_valid & o_req_ready;

    always_comb begin
        req_entry.addr    = i_req_addr;
        req_entry.pc_line = {i_req_pc[AXI_ADDR_W-1:LINE_BYTE_OFFSET], {LINE_BYTE_OFFSET{1'b0}}};
        req_entry.len     = i_req_len;
    end

    assign o_arsize  = axi_size_for(AXI_DATA_W);    // full-width beats
    assign o_arburst = AXI_BURST_INCR;
    assign o_rready  = 1'b1;                        // beats are never stalled

    refill_queue #(
        .LINE_BYTE_OFFSET (LINE_BYTE_OFFSET),
        .QUEUE_DEPTH      (QUEUE_DEPTH)
    ) refill_queue_i (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_push  (req_push),
        .i_entry (req_entry),
        .o_full  (queue_full),
        .head    (head_if.queue_side)
    );

    burst_reader #(
        .LINE_BYTE_OFFSET (LINE_BYTE_OFFSET)
    ) burst_reader_i (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .head         (head_if.reader_side),
        .o_arvalid    (o_arvalid),
        .o_araddr     (o_araddr),
        .o_arlen      (o_arlen),
        .i_arready    (i_arready),
        .i_rvalid     (i_rvalid),
        .i_rdata      (i_rdata),
        .i_rlast      (i_rlast),
        .o_beat_valid (o_beat_valid),
        .o_beat_data  (o_beat_data),
        .o_beat_addr  (o_beat_addr),
        .o_beat_pc    (o_beat_pc),
        .o_beat_last  (o_beat_last),
        .o_idle       (o_idle)
    );

endmodule

`default_nettype wire

/* tests/mem_refill_assert.sv */
`default_nettype none

module mem_refill_assert
    import axi_read_pkg::*;
(
    input wire logic                  i_clk,
    input wire logic                  i_rst,
    input wire logic                  i_arvalid,
    input wire logic [AXI_ADDR_W-1:0] i_araddr,
    input wire logic [AXI_LEN_W-1:0]  i_arlen,
    input wire logic                  i_arready,
    input wire logic                  i_beat_valid,
    input wire logic                  i_beat_last,
    input wire logic                  i_req_ready,
    input wire logic                  i_idle
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [AXI_LEN_W-1:0] burst_len_q;     // arlen taken at the AR handshake
    logic [AXI_LEN_W-1:0] beat_cnt_q;
    logic                 in_burst_q;
    int unsigned          error_count = 0;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            in_burst_q  <= 1'b0;
            burst_len_q <= '0;
            beat_cnt_q  <= '0;
        end else if (i_arvalid && i_arready) begin
            in_burst_q  <= 1'b1;
            burst_len_q <= i_arlen;
            beat_cnt_q  <= '0;
        end else if (i_beat_valid) begin
            beat_cnt_q <= beat_cnt_q + 1'b1;
            if (i_beat_last) begin
                in_burst_q <= 1'b0;
            end
        end
    end

    reset_state: assert property (@(posedge i_clk)
        i_rst |=> (!i_arvalid && !i_beat_valid && i_req_ready && i_idle))
        else begin
            $error("outputs not at their reset values");
            error_count++;
        end

    ar_stable: assert property (@(posedge i_clk) disable iff (i_rst)
        (i_arvalid && !i_arready) |=> (i_arvalid && $stable(i_araddr) && $stable(i_arlen)))
        else begin
            $error("AR request changed before arready");
            error_count++;
        end

    no_ar_in_burst: assert property (@(posedge i_clk) disable iff (i_rst)
        in_burst_q |-> !i_arvalid)
        else begin
            $error("new AR while a burst is in flight");
            error_count++;
        end

    beat_in_burst: assert property (@(posedge i_clk) disable iff (i_rst)
        i_beat_valid |-> in_burst_q)
        else begin
            $error("beat outside of any burst");
            error_count++;
        end

    last_on_count: assert property (@(posedge i_clk) disable iff (i_rst)
        i_beat_valid |-> (i_beat_last == (beat_cnt_q == burst_len_q)))
        else begin
            $error("beat_last disagrees with the beat count");
            error_count++;
        end

endmodule

bind mem_refill mem_refill_assert mem_refill_assert_i (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_arvalid    (o_arvalid),
    .i_araddr     (o_araddr),
    .i_arlen      (o_arlen),
    .i_arready    (i_arready),
    .i_beat_valid (o_beat_valid),
    .i_beat_last  (o_beat_last),
    .i_req_ready  (o_req_ready),
    .i_idle       (o_idle)
);

`default_nettype wire

/* tests/tb_mem_refill.sv */
`default_nettype none

module tb_mem_refill
    import axi_read_pkg::*;
    import refill_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int LINE_BYTE_OFFSET = 6;
    localparam int QUEUE_DEPTH      = 4;
    localparam int NUM_REQ          = 40;
    localparam int TIMEOUT          = 400;     // cycles per wait
    localparam logic [31:0] PC_MASK = ~((32'd1 << LINE_BYTE_OFFSET) - 32'd1);

    logic                   i_clk;
    logic                   i_rst;
    logic                   i_req_valid;
    logic [AXI_ADDR_W-1:0]  i_req_addr;
    logic [AXI_ADDR_W-1:0]  i_req_pc;
    logic [REQ_LEN_W-1:0]   i_req_len;
    logic                   o_req_ready;
    logic                   o_arvalid;
    logic [AXI_ADDR_W-1:0]  o_araddr;
    logic [AXI_LEN_W-1:0]   o_arlen;
    logic [AXI_SIZE_W-1:0]  o_arsize;
    logic [AXI_BURST_W-1:0] o_arburst;
    logic                   o_rready;
    logic                   i_arready;
    logic                   i_rvalid;
    logic [AXI_DATA_W-1:0]  i_rdata;
    logic                   i_rlast;
    logic                   o_beat_valid;
    logic [AXI_DATA_W-1:0]  o_beat_data;
    logic [AXI_ADDR_W-1:0]  o_beat_addr;
    logic [AXI_ADDR_W-1:0]  o_beat_pc;
    logic                   o_beat_last;
    logic                   o_idle;

    logic [31:0]   lfsr_q = 32'h7b1d_0365;
    logic          hold_ar;                    // forces arready low
    int            mismatch_errors = 0;
    int            other_errors = 0;
    int            occupancy = 0;              // accepted but not yet popped
    int            beat_k;
    refill_entry_t exp_q[$];

    mem_refill #(
        .LINE_BYTE_OFFSET (LINE_BYTE_OFFSET),
        .QUEUE_DEPTH      (QUEUE_DEPTH)
    ) mem_refill_i (.*);

    initial i_clk = 1'b0;
    always #4 i_clk = ~i_clk;

    function automatic logic [31:0] next_lfsr(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};    // taps 32 22 2 1
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = next_lfsr(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    task automatic compare_word(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        assert (got === exp) else begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            mismatch_errors++;
        end
    endtask

    task automatic drive_request();
        i_req_valid = 1'b1;
        i_req_addr  = take_bits(30) << 2;       // beat aligned
        i_req_pc    = take_bits(32);
        i_req_len   = REQ_LEN_W'(take_bits(REQ_LEN_W));
    endtask

    task automatic await_accept();
        int cycles;
        cycles = 0;
        @(negedge i_clk);
        while (!o_req_ready && cycles < TIMEOUT) begin
            @(negedge i_clk);
            cycles++;
        end
        if (!o_req_ready) begin
            $display("request was not accepted within %0d cycles", TIMEOUT);
            other_errors++;
        end
        @(posedge i_clk);
        #1;
        i_req_valid = 1'b0;
    endtask

    task automatic wait_idle();
        int cycles;
        cycles = 0;
        @(negedge i_clk);
        while (!o_idle && cycles < TIMEOUT * 8) begin
            @(negedge i_clk);
            cycles++;
        end
        if (!o_idle) begin
            $display("subsystem did not return to idle");
            other_errors++;
        end
        @(posedge i_clk);
        #1;
    endtask

    // AXI slave with one burst in flight and data equal to the inverted byte address
    initial begin : axi_slave
        logic        busy;
        logic        ar_n;
        logic        rv_n;
        logic [31:0] cur_addr;
        int          left;
        i_arready = 1'b0;
        i_rvalid  = 1'b0;
        i_rdata   = '0;
        i_rlast   = 1'b0;
        busy      = 1'b0;
        cur_addr  = '0;
        left      = 0;
        forever begin
            @(negedge i_clk);
            ar_n = 1'b0;
            rv_n = 1'b0;
            if (i_rst) begin
                busy = 1'b0;
            end else begin
                if (i_rvalid) begin            // taken at the coming edge
                    cur_addr = cur_addr + BEAT_BYTES;
                    if (left == 0) busy = 1'b0;
                    else left--;
                end
                if (o_arvalid && i_arready) begin
                    busy     = 1'b1;
                    cur_addr = o_araddr;
                    left     = o_arlen;
                end
                ar_n = !busy && !hold_ar && (take_bits(2) != 0);
                rv_n = busy && (take_bits(2) != 0);     // random gaps
            end
            @(posedge i_clk);
            #1;
            i_arready = ar_n;
            i_rvalid  = rv_n;
            i_rdata   = ~cur_addr;
            i_rlast   = rv_n && (left == 0);
        end
    end

    // scoreboard sampled mid cycle
    always @(negedge i_clk) begin
        logic [31:0] exp_addr;
        if (!i_rst) begin
            compare_word("o_req_ready", o_req_ready, occupancy < QUEUE_DEPTH);
            compare_word("o_idle", o_idle, occupancy == 0);
            compare_word("o_rready", o_rready, 1'b1);
            if (o_arvalid && i_arready) begin
                if (exp_q.size() == 0) begin
                    $display("AR issued with no request outstanding");
                    other_errors++;
                end else begin
                    compare_word("o_araddr", o_araddr, exp_q[0].addr);
                    compare_word("o_arlen", o_arlen, exp_q[0].len);
                    compare_word("o_arsize", o_arsize, 3'd2);
                    compare_word("o_arburst", o_arburst, 2'b01);
                end
                beat_k = 0;
            end
            if (o_beat_valid && exp_q.size() == 0) begin
                $display("beat delivered with no request outstanding");
                other_errors++;
            end else if (o_beat_valid) begin
                exp_addr = exp_q[0].addr + BEAT_BYTES * beat_k;
                compare_word("o_beat_addr", o_beat_addr, exp_addr);
                compare_word("o_beat_data", o_beat_data, ~exp_addr);
                compare_word("o_beat_pc", o_beat_pc, exp_q[0].pc_line + BEAT_BYTES * beat_k);
                compare_word("o_beat_last", o_beat_last, beat_k == exp_q[0].len);
                beat_k++;
                if (o_beat_last) begin
                    void'(exp_q.pop_front());
                    occupancy--;
                end
            end
            if (i_req_valid && o_req_ready) begin
                exp_q.push_back('{addr: i_req_addr, pc_line: i_req_pc & PC_MASK,
                                  len: i_req_len});
                occupancy++;
            end
        end
    end

    initial begin
        int gap;
        int total;
        i_rst       = 1'b1;
        i_req_valid = 1'b0;
        i_req_addr  = '0;
        i_req_pc    = '0;
        i_req_len   = '0;
        hold_ar     = 1'b0;
        repeat (3) @(posedge i_clk);
        #1;
        i_rst = 1'b0;
        @(negedge i_clk);
        compare_word("o_arvalid", o_arvalid, 1'b0);
        compare_word("o_beat_valid", o_beat_valid, 1'b0);
        compare_word("o_req_ready", o_req_ready, 1'b1);
        compare_word("o_idle", o_idle, 1'b1);
        @(posedge i_clk);
        #1;

        for (int n = 0; n < NUM_REQ; n++) begin
            gap = take_bits(2);
            repeat (gap) begin
                @(posedge i_clk);
                #1;
            end
            drive_request();
            await_accept();
        end
        wait_idle();

        // fill the queue while AR is stalled so one more request has to wait
        hold_ar = 1'b1;
        for (int n = 0; n < QUEUE_DEPTH; n++) begin
            drive_request();
            await_accept();
        end
        drive_request();
        repeat (4) @(negedge i_clk);
        compare_word("o_req_ready", o_req_ready, 1'b0);
        @(posedge i_clk);
        #1;
        hold_ar = 1'b0;
        await_accept();
        wait_idle();
        if (exp_q.size() != 0) begin
            $display("%0d requests never received their burst", exp_q.size());
            other_errors++;
        end

        total = mismatch_errors + other_errors + mem_refill_i.mem_refill_assert_i.error_count;
        $display("errors: mismatch %0d, other %0d, assertion %0d", mismatch_errors,
                 other_errors, mem_refill_i.mem_refill_assert_i.error_count);
        if (total == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
logic/axi_read_pkg.sv
logic/refill_pkg.sv
logic/refill_head_if.sv
logic/refill_queue.sv
logic/burst_reader.sv
logic/mem_refill.sv
tests/mem_refill_assert.sv
tests/tb_mem_refill.sv

/* Bender.yml */
package:
  name: mem_refill

sources:
  # packages first, then the RTL in dependency order
  - logic/axi_read_pkg.sv
  - logic/refill_pkg.sv
  - logic/refill_head_if.sv
  - logic/refill_queue.sv
  - logic/burst_reader.sv
  - logic/mem_refill.sv

  - target: test
    files:
      - tests/mem_refill_assert.sv
      - tests/tb_mem_refill.sv
